// File: rv_pkg.sv
/* Shared widths, opcode and ALU operation enums,
   control field encodings and the fetch bundle struct */
`default_nettype none

package rv_pkg;

   parameter int XLEN       = 32;            // Data and address width
   parameter int REG_ADDR_W = 5;             // Register index width

   // RV32I major opcodes handled by the core
   typedef enum logic [6:0] {
      OP       = 7'b0110011,                 // Register-register ALU
      OP_IMM   = 7'b0010011,                 // Register-immediate ALU
      BRANCH   = 7'b1100011,                 // Conditional branches
      JAL      = 7'b1101111,
      JALR     = 7'b1100111,
      LUI      = 7'b0110111,
      AUIPC    = 7'b0010111,
      STORE    = 7'b0100011,                 // sb, sh, sw
      NOP_ZERO = 7'b0000000                  // Cleared pipeline slot
   } opcode_e;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      AND,
      XOR,
      OR,
      SLL,
      SRL,
      SRA,                                   // Arithmetic right shift
      EQ,                                    // Compare results are 0 or 1
      LT,
      LTU
   } alu_op_e;

   typedef enum logic [2:0] {
      I,                                     // ALU imm, jalr
      S,                                     // Stores
      B,                                     // Branches
      U,                                     // lui, auipc
      J                                      // jal
   } imm_fmt_e;

   typedef enum logic [1:0] {
      ALU,
      PC_PLUS4,                              // Link value
      IMM,                                   // lui
      TARGET                                 // auipc
   } result_sel_e;

   typedef enum logic [1:0] {
      BYTE,
      HALF,
      WORD
   } store_fmt_e;

   // Fetch/decode pipeline register contents
   typedef struct packed {
      logic [XLEN-1:0] inst;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] pc_plus4;
   } fd_word_t;

endpackage

`default_nettype wire

// File: rv_ctrl_if.sv
/* Decoded control bundle from the controller
   to the decode, execute and store modules */
`timescale 1ns/1ns
`default_nettype none

interface rv_ctrl_if;

   import rv_pkg::*;

   logic        reg_wen;                     // Write rd at end of execute
   imm_fmt_e    imm_fmt;                     // Immediate layout
   logic        alu_src_imm;                 // Operand B from immediate
   alu_op_e     alu_op;
   logic        target_from_rs1;             // jalr base is rs1, else PC
   result_sel_e result_sel;                  // Writeback source
   logic        store_en;
   store_fmt_e  store_fmt;                   // Store width

   // Controller drives every field
   modport ctrl (
      output reg_wen,
      output imm_fmt,
      output alu_src_imm,
      output alu_op,
      output target_from_rs1,
      output result_sel,
      output store_en,
      output store_fmt
   );

   modport decode (
      input reg_wen,
      input imm_fmt
   );

   modport exec (
      input alu_src_imm,
      input alu_op,
      input target_from_rs1,
      input result_sel
   );

   modport store (
      input store_en,
      input store_fmt
   );

endinterface

`default_nettype wire

// File: fetch_unit.sv
/* Program counter with redirect and stall,
   fetch/decode pipeline register */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
   parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    stall_i,
   input  wire [rv_pkg::XLEN-1:0] inst_i,        // Word at pc_o, same cycle
   input  wire                    redirect_i,    // From the executing instruction
   input  wire [rv_pkg::XLEN-1:0] target_i,
   output logic [rv_pkg::XLEN-1:0] pc_o,
   output rv_pkg::fd_word_t       fd_o
);

   import rv_pkg::*;

   logic [XLEN-1:0] pc_plus4;

   assign pc_plus4 = pc_o + XLEN'(4);

   // Redirect wins over stall so a taken transfer is never dropped
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pc_o <= RESET_PC;
      end else if (redirect_i) begin
         pc_o <= target_i;
      end else if (!stall_i) begin
         pc_o <= pc_plus4;
      end
   end

   // Squash the slot on stall or redirect; it is refetched later
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         fd_o <= '0;
      end else if (stall_i || redirect_i) begin
         fd_o <= '0;                             // Becomes NOP_ZERO in execute
      end else begin
         fd_o.inst     <= inst_i;
         fd_o.pc       <= pc_o;
         fd_o.pc_plus4 <= pc_plus4;
      end
   end

endmodule

`default_nettype wire

// File: decode_unit.sv
/* Register file with hard-wired x0
   and the I/S/B/U/J immediate extender */
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
   input  wire                     clk_i,
   input  wire rv_pkg::fd_word_t   fd_i,
   rv_ctrl_if.decode               ctrl,
   input  wire [rv_pkg::XLEN-1:0]  result_i,     // Writeback value for rd
   output logic [rv_pkg::XLEN-1:0] rs1_val_o,
   output logic [rv_pkg::XLEN-1:0] rs2_val_o,
   output logic [rv_pkg::XLEN-1:0] imm_o
);

   import rv_pkg::*;

   logic [XLEN-1:0]       regs [2**REG_ADDR_W];  // x0 entry never read
   logic [REG_ADDR_W-1:0] rs1_addr;
   logic [REG_ADDR_W-1:0] rs2_addr;
   logic [REG_ADDR_W-1:0] rd_addr;
   logic [XLEN-1:0]       inst;

   assign inst     = fd_i.inst;
   assign rs1_addr = inst[19:15];
   assign rs2_addr = inst[24:20];
   assign rd_addr  = inst[11:7];

   // Read in the same cycle, so no forwarding is needed
   assign rs1_val_o = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_val_o = (rs2_addr == '0) ? '0 : regs[rs2_addr];

   always_ff @(posedge clk_i) begin
      if (ctrl.reg_wen) begin
         regs[rd_addr] <= result_i;              // End of execute cycle
      end
   end

   always_comb begin
      case (ctrl.imm_fmt)
         I:       imm_o = {{20{inst[31]}}, inst[31:20]};
         S:       imm_o = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         B:       imm_o = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
         U:       imm_o = {inst[31:12], 12'b0};
         J:       imm_o = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
         default: imm_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: control_unit.sv
/* Opcode decoder, ALU operation selection
   and branch resolution with redirect */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
   input  wire rv_pkg::fd_word_t fd_i,
   input  wire                   alu_zero_i,     // Compare result was 0
   rv_ctrl_if.ctrl               ctrl,
   output logic                  redirect_o      // Load target into PC
);

   import rv_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic       funct7_5;                         // SUB and SRA select
   logic       is_branch;
   logic       is_jump;
   logic       branch_taken;

   assign opcode   = opcode_e'(fd_i.inst[6:0]);
   assign funct3   = fd_i.inst[14:12];
   assign funct7_5 = fd_i.inst[30];

   always_comb begin
      ctrl.reg_wen         = 1'b0;               // Defaults leave no side effects
      ctrl.imm_fmt         = I;
      ctrl.alu_src_imm     = 1'b0;
      ctrl.target_from_rs1 = 1'b0;
      ctrl.result_sel      = ALU;
      ctrl.store_en        = 1'b0;
      is_branch            = 1'b0;
      is_jump              = 1'b0;
      case (opcode)
         OP: begin
            ctrl.reg_wen = 1'b1;
         end
         OP_IMM: begin
            ctrl.reg_wen     = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         BRANCH: begin
            ctrl.imm_fmt = B;
            is_branch    = 1'b1;
         end
         JAL: begin
            ctrl.reg_wen    = 1'b1;
            ctrl.imm_fmt    = J;
            ctrl.result_sel = PC_PLUS4;          // Link
            is_jump         = 1'b1;
         end
         JALR: begin
            ctrl.reg_wen         = 1'b1;
            ctrl.target_from_rs1 = 1'b1;
            ctrl.result_sel      = PC_PLUS4;
            is_jump              = 1'b1;
         end
         LUI: begin
            ctrl.reg_wen    = 1'b1;
            ctrl.imm_fmt    = U;
            ctrl.result_sel = IMM;
         end
         AUIPC: begin
            ctrl.reg_wen    = 1'b1;
            ctrl.imm_fmt    = U;
            ctrl.result_sel = TARGET;            // PC plus upper immediate
         end
         STORE: begin
            ctrl.imm_fmt     = S;
            ctrl.alu_src_imm = 1'b1;             // Address is rs1 plus offset
            ctrl.store_en    = 1'b1;
         end
         NOP_ZERO: begin
         end
         default: begin
         end
      endcase
   end

   assign ctrl.store_fmt = store_fmt_e'(funct3[1:0]);   // sb, sh, sw

   always_comb begin
      ctrl.alu_op = ADD;                         // Stores and the rest add
      if (is_branch) begin
         case (funct3[2:1])
            2'b10:   ctrl.alu_op = LT;
            2'b11:   ctrl.alu_op = LTU;
            default: ctrl.alu_op = EQ;           // beq, bne
         endcase
      end else if (opcode == OP || opcode == OP_IMM) begin
         case (funct3)
            3'b000:  ctrl.alu_op = (opcode == OP && funct7_5) ? SUB : ADD;
            3'b001:  ctrl.alu_op = SLL;
            3'b010:  ctrl.alu_op = LT;
            3'b011:  ctrl.alu_op = LTU;
            3'b100:  ctrl.alu_op = XOR;
            3'b101:  ctrl.alu_op = funct7_5 ? SRA : SRL;
            3'b110:  ctrl.alu_op = OR;
            default: ctrl.alu_op = AND;
         endcase
      end
   end

   // beq/blt/bltu take on compare true, the inverses on compare false
   always_comb begin
      case (funct3)
         3'b000, 3'b100, 3'b110: branch_taken = !alu_zero_i;
         3'b001, 3'b101, 3'b111: branch_taken = alu_zero_i;
         default:                branch_taken = 1'b0;
      endcase
   end

   assign redirect_o = (is_branch && branch_taken) || is_jump;

endmodule

`default_nettype wire

// File: execute_unit.sv
/* ALU, jump/branch target adder
   and writeback source selector */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
   input  wire rv_pkg::fd_word_t   fd_i,
   rv_ctrl_if.exec                 ctrl,
   input  wire [rv_pkg::XLEN-1:0]  rs1_val_i,
   input  wire [rv_pkg::XLEN-1:0]  rs2_val_i,
   input  wire [rv_pkg::XLEN-1:0]  imm_i,
   output logic [rv_pkg::XLEN-1:0] alu_out_o,    // Also store address
   output logic                    alu_zero_o,
   output logic [rv_pkg::XLEN-1:0] target_o,
   output logic [rv_pkg::XLEN-1:0] result_o
);

   import rv_pkg::*;

   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] target_base;
   logic [XLEN-1:0] target_sum;

   assign op_b = ctrl.alu_src_imm ? imm_i : rs2_val_i;

   always_comb begin
      case (ctrl.alu_op)
         ADD:     alu_out_o = rs1_val_i + op_b;
         SUB:     alu_out_o = rs1_val_i - op_b;
         AND:     alu_out_o = rs1_val_i & op_b;
         XOR:     alu_out_o = rs1_val_i ^ op_b;
         OR:      alu_out_o = rs1_val_i | op_b;
         SLL:     alu_out_o = rs1_val_i << op_b[4:0];
         SRL:     alu_out_o = rs1_val_i >> op_b[4:0];
         SRA:     alu_out_o = $unsigned($signed(rs1_val_i) >>> op_b[4:0]);
         EQ:      alu_out_o = {{(XLEN-1){1'b0}}, rs1_val_i == op_b};
         LT:      alu_out_o = {{(XLEN-1){1'b0}}, $signed(rs1_val_i) < $signed(op_b)};
         LTU:     alu_out_o = {{(XLEN-1){1'b0}}, rs1_val_i < op_b};
         default: alu_out_o = '0;
      endcase
   end

   assign alu_zero_o = (alu_out_o == '0);         // Drives branch decision

   // PC relative except jalr
   assign target_base = ctrl.target_from_rs1 ? rs1_val_i : fd_i.pc;
   assign target_sum  = target_base + imm_i;
   assign target_o    = {target_sum[XLEN-1:1], target_sum[0] & ~ctrl.target_from_rs1};

   always_comb begin
      case (ctrl.result_sel)
         ALU:      result_o = alu_out_o;
         PC_PLUS4: result_o = fd_i.pc_plus4;     // jal, jalr link
         IMM:      result_o = imm_i;
         TARGET:   result_o = target_o;
         default:  result_o = alu_out_o;
      endcase
   end

endmodule

`default_nettype wire

// File: store_unit.sv
/* Store byte strobes and write data alignment */
`timescale 1ns/1ns
`default_nettype none

module store_unit (
   rv_ctrl_if.store                ctrl,
   input  wire [rv_pkg::XLEN-1:0]  addr_i,       // rs1 plus S immediate
   input  wire [rv_pkg::XLEN-1:0]  wdata_i,      // rs2
   output logic                    wen_o,
   output logic [3:0]              stb_o,
   output logic [rv_pkg::XLEN-1:0] data_addr_o,
   output logic [rv_pkg::XLEN-1:0] data_o
);

   import rv_pkg::*;

   logic [1:0] byte_off;

   assign byte_off    = addr_i[1:0];
   assign data_addr_o = addr_i;
   assign wen_o       = ctrl.store_en;
   assign data_o      = wdata_i << {byte_off, 3'b000};   // Move data to its lane

   always_comb begin
      stb_o = 4'b0000;                           // No lanes without a store
      if (ctrl.store_en) begin
         case (ctrl.store_fmt)
            BYTE:    stb_o = 4'b0001 << byte_off;
            HALF:    stb_o = 4'b0011 << byte_off;
            WORD:    stb_o = 4'b1111 << byte_off;
            default: stb_o = 4'b0000;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rv_core_top.sv
/* Two-stage RV32I core top level
   Fetch, decode, control, execute and store instances */
`timescale 1ns/1ns
`default_nettype none

module rv_core_top #(
   parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0   // First fetch address, word aligned
) (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    stall_i,       // Holds PC, clears fetch slot
   input  wire [rv_pkg::XLEN-1:0] inst_i,        // Combinational instruction memory
   output wire [rv_pkg::XLEN-1:0] inst_addr_o,
   output wire                    wen_o,         // Store strobe, one cycle
   output wire [3:0]              stb_o,         // Byte lanes
   output wire [rv_pkg::XLEN-1:0] data_addr_o,
   output wire [rv_pkg::XLEN-1:0] data_o
);

   import rv_pkg::*;

   fd_word_t        fd;                          // Instruction in execute
   logic            redirect;                    // Taken branch or jump
   logic [XLEN-1:0] target;
   logic [XLEN-1:0] rs1_val;
   logic [XLEN-1:0] rs2_val;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] alu_out;                     // Also the store address
   logic            alu_zero;
   logic [XLEN-1:0] result;                      // Writeback value

   rv_ctrl_if ctrl_bus ();

   fetch_unit #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .inst_i     (inst_i),
      .redirect_i (redirect),
      .target_i   (target),
      .pc_o       (inst_addr_o),
      .fd_o       (fd)
   );

   decode_unit u_decode (
      .clk_i     (clk_i),
      .fd_i      (fd),
      .ctrl      (ctrl_bus.decode),
      .result_i  (result),
      .rs1_val_o (rs1_val),
      .rs2_val_o (rs2_val),
      .imm_o     (imm)
   );

   control_unit u_control (
      .fd_i       (fd),
      .alu_zero_i (alu_zero),
      .ctrl       (ctrl_bus.ctrl),
      .redirect_o (redirect)
   );

   execute_unit u_execute (
      .fd_i       (fd),
      .ctrl       (ctrl_bus.exec),
      .rs1_val_i  (rs1_val),
      .rs2_val_i  (rs2_val),
      .imm_i      (imm),
      .alu_out_o  (alu_out),
      .alu_zero_o (alu_zero),
      .target_o   (target),
      .result_o   (result)
   );

   store_unit u_store (
      .ctrl        (ctrl_bus.store),
      .addr_i      (alu_out),
      .wdata_i     (rs2_val),                   // Store data is rs2
      .wen_o       (wen_o),
      .stb_o       (stb_o),
      .data_addr_o (data_addr_o),
      .data_o      (data_o)
   );

endmodule

`default_nettype wire

// File: tb_iss.svh
/* Random program generator and instruction-set model
   producing the expected fetch sequence and store trace */
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

localparam int          PROG_LEN = 64;
localparam int          NREG     = 8;                     // Programs touch x0..x7 only
localparam logic [31:0] FINAL_PC = RESET_PC + 32'(4 * (PROG_LEN - 1));   // jal-to-self

logic [31:0] prog    [PROG_LEN];                           // Program image
logic        taken   [PROG_LEN];                           // Transfer taken, per executed word
logic [31:0] jump_to [PROG_LEN];                           // Next PC, per executed word
logic [31:0] exp_fetch [$];                                // Fetch addresses without stall
logic [31:0] exp_addr  [$];
logic [3:0]  exp_stb   [$];
logic [31:0] exp_data  [$];

function automatic logic [5:0] idx_of(input logic [31:0] addr);
   logic [31:0] rel;
   rel = addr - RESET_PC;
   return rel[7:2];                                        // Word number in the image
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
   logic [31:0] sra;
   sra = $signed(a) >>> b[4:0];
   case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? sra : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
   case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
   endcase
endfunction

// Forward-only control flow so every word runs at most once
task automatic gen_program();
   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [2:0]  f3;
   logic [11:0] imm;
   logic [20:0] off;
   logic        alt;
   int          k;
   int          lim;
   for (k = 0; k < PROG_LEN; k++) begin
      rd  = 5'($urandom % NREG);
      rs1 = 5'($urandom % NREG);
      rs2 = 5'($urandom % NREG);
      f3  = 3'($urandom);
      imm = 12'($urandom);
      lim = (PROG_LEN - 1 - k > 4) ? 4 : PROG_LEN - 1 - k;       // Stay inside the image
      off = (lim > 0) ? 21'(4 * (1 + $urandom % lim)) : 21'd0;
      if (k < NREG - 1) begin
         prog[6'(k)] = {imm, 5'd0, 3'b000, 5'(k + 1), 7'b0010011};   // addi x(k+1), x0
      end else if (k == PROG_LEN - 1) begin
         prog[6'(k)] = {25'd0, 7'b1101111};                    // jal x0, 0
      end else begin
         case ($urandom % 12)
            0, 1, 2: begin
               alt = 1'($urandom) & (f3 == 3'd0 || f3 == 3'd5);   // sub, sra
               prog[6'(k)] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
            end
            3, 4: begin
               if (f3 == 3'd1) imm[11:5] = 7'd0;                  // slli
               if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0}; // srli or srai
               prog[6'(k)] = {imm, rs1, f3, rd, 7'b0010011};
            end
            5: prog[6'(k)] = {20'($urandom), rd, (($urandom % 2 == 0) ? 7'b0110111 : 7'b0010111)};
            6: begin
               if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;      // No such branches
               prog[6'(k)] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            7: prog[6'(k)] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            8: begin
               imm = 12'(RESET_PC + 4 * k + off) | 12'($urandom % 2);   // Odd target too
               prog[6'(k)] = {imm, 5'd0, 3'b000, rd, 7'b1100111};
            end
            default: begin
               f3  = 3'($urandom % 3);                            // sb, sh, sw
               imm = 12'(12'h100 + 4 * ($urandom % 64));          // Data area word
               if (f3 == 3'd0) imm[1:0] = 2'($urandom);           // Any byte lane
               if (f3 == 3'd1) imm[1] = 1'($urandom);             // Either half
               prog[6'(k)] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
            end
         endcase
      end
   end
endtask

task automatic run_model();
   logic [31:0] x [32];
   logic [31:0] pc;
   logic [31:0] ins;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] res;
   logic [31:0] nxt;
   logic [31:0] addr;
   logic [3:0]  lanes;
   logic        take;
   logic        wr;
   int          n;
   x = '{default: '0};
   for (n = 0; n < PROG_LEN; n++) begin
      taken[6'(n)]   = 1'b0;
      jump_to[6'(n)] = '0;
   end
   pc = RESET_PC;
   for (n = 0; n <= PROG_LEN; n++) begin
      exp_fetch.push_back(pc);
      if (pc == FINAL_PC) break;
      ins  = prog[idx_of(pc)];
      a    = x[ins[19:15]];
      b    = x[ins[24:20]];
      take = 1'b0;
      wr   = 1'b1;
      res  = '0;
      nxt  = pc + 32'd4;
      case (ins[6:0])
         7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
         7'b0010011: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a,
                                   {{20{ins[31]}}, ins[31:20]});
         7'b0110111: res = {ins[31:12], 12'd0};
         7'b0010111: res = pc + {ins[31:12], 12'd0};
         7'b1101111: begin
            res  = pc + 32'd4;                                 // Link
            nxt  = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            take = 1'b1;
         end
         7'b1100111: begin
            res  = pc + 32'd4;
            nxt  = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
            take = 1'b1;
         end
         7'b1100011: begin
            wr   = 1'b0;
            take = branch_ref(ins[14:12], a, b);
            if (take) nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         default: begin                                        // Store
            wr    = 1'b0;
            addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            lanes = (ins[13:12] == 2'd0) ? 4'b0001 : (ins[13:12] == 2'd1) ? 4'b0011 : 4'b1111;
            exp_addr.push_back(addr);
            exp_stb.push_back(lanes << addr[1:0]);
            exp_data.push_back(b << (8 * addr[1:0]));
         end
      endcase
      if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
      taken[idx_of(pc)]   = take;
      jump_to[idx_of(pc)] = nxt;
      if (take) begin
         exp_fetch.push_back(pc + 32'd4);                      // Squashed fetch
         if (pc + 32'd4 == FINAL_PC) break;
      end
      pc = nxt;
   end
endtask

`endif

// File: tb_rv_core.sv
/* Testbench for the RV32I core: clock, reset, program memory,
   random stall and per-cycle checks against the instruction-set model */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

   localparam logic [31:0] RESET_PC   = 32'h0000_0400;
   localparam int          CLK_PERIOD = 100;
   localparam int          DRIVE_DLY  = 10;           // Input change after rising edge

   logic        clk_i;
   logic        rst_i;
   logic        stall_i;
   logic [31:0] inst_i;
   wire  [31:0] inst_addr_o;
   wire         wen_o;
   wire  [3:0]  stb_o;
   wire  [31:0] data_addr_o;
   wire  [31:0] data_o;

   int          errors;
   int          stall_cycles;
   int          total_cycles = 0;
   int          fetch_idx;
   int          store_idx;
   logic [31:0] exp_pc;                               // Cycle model of the PC
   logic [31:0] slot_pc;                              // Word in the execute slot
   logic        slot_valid;

   `include "tb_iss.svh"

   rv_core_top #(
      .RESET_PC (RESET_PC)
   ) uut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .stall_i     (stall_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .wen_o       (wen_o),
      .stb_o       (stb_o),
      .data_addr_o (data_addr_o),
      .data_o      (data_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // Combinational program memory, zero outside the image
   assign inst_i = (inst_addr_o - RESET_PC < 32'(4 * PROG_LEN)) ? prog[idx_of(inst_addr_o)] : '0;

   // Both runs plus resets, stretched by every stall cycle
   always @(posedge clk_i) begin
      total_cycles++;
      if (total_cycles > 2 * (8 * PROG_LEN + 4) + stall_cycles) begin
         $display("timeout: final fetch address not reached after %0d cycles", total_cycles);
         $display("checks aborted: %0d errors", errors + 1);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("at %0t ns: %s", $time, what);
   endtask

   task automatic check_cycle(input logic use_stall);
      logic [5:0] si;
      si = idx_of(slot_pc);
      assert (inst_addr_o == exp_pc) else report_mismatch("inst_addr_o", inst_addr_o, exp_pc);
      if (!use_stall) begin
         assert (fetch_idx < exp_fetch.size())
            else report_failure("fetch continued past the expected fetch sequence");
         if (fetch_idx < exp_fetch.size()) begin
            assert (inst_addr_o == exp_fetch[fetch_idx])
               else report_mismatch("inst_addr_o", inst_addr_o, exp_fetch[fetch_idx]);
         end
         fetch_idx++;
      end
      if (wen_o) begin
         assert (slot_valid && prog[si][6:0] == 7'b0100011)
            else report_failure("wen_o raised without a store in the execute slot");
         assert (store_idx < exp_addr.size()) else report_failure("store beyond the expected trace");
         if (store_idx < exp_addr.size()) begin
            assert (data_addr_o == exp_addr[store_idx])
               else report_mismatch("data_addr_o", data_addr_o, exp_addr[store_idx]);
            assert (stb_o == exp_stb[store_idx])
               else report_mismatch("stb_o", {28'd0, stb_o}, {28'd0, exp_stb[store_idx]});
            assert (data_o == exp_data[store_idx])
               else report_mismatch("data_o", data_o, exp_data[store_idx]);
         end
         store_idx++;
      end
   endtask

   // PC and execute slot after the coming edge
   task automatic advance_model();
      logic [5:0] si;
      si = idx_of(slot_pc);
      if (slot_valid && taken[si]) begin
         exp_pc     = jump_to[si];                    // Redirect wins over stall
         slot_valid = 1'b0;                           // Next word squashed
      end else if (stall_i) begin
         slot_valid = 1'b0;                           // PC holds, slot cleared
      end else begin
         slot_pc    = exp_pc;
         slot_valid = 1'b1;
         exp_pc     = exp_pc + 32'd4;
      end
   endtask

   task automatic run_program(input logic use_stall);
      logic done;
      rst_i   = 1'b1;
      stall_i = 1'b0;
      repeat (4) @(posedge clk_i);
      #DRIVE_DLY;
      assert (inst_addr_o == RESET_PC) else report_mismatch("inst_addr_o", inst_addr_o, RESET_PC);
      assert (!wen_o && stb_o == 4'd0) else report_failure("store bus active during reset");
      rst_i      = 1'b0;
      exp_pc     = RESET_PC;
      slot_pc    = RESET_PC;
      slot_valid = 1'b0;
      fetch_idx  = 0;
      store_idx  = 0;
      done       = 1'b0;
      while (!done) begin
         stall_i = use_stall && ($urandom % 4 == 0);  // About one cycle in four
         if (stall_i) stall_cycles++;
         #(CLK_PERIOD / 2);                           // Mid-cycle, outputs settled
         check_cycle(use_stall);
         done = (inst_addr_o == FINAL_PC);
         advance_model();
         @(posedge clk_i);
         #DRIVE_DLY;
      end
      stall_i = 1'b0;
      assert (store_idx == exp_addr.size()) else report_failure("store trace ended early");
      if (!use_stall) begin
         assert (fetch_idx == exp_fetch.size()) else report_failure("fetch sequence ended early");
      end
   endtask

   initial begin
      errors       = 0;
      stall_cycles = 0;
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      stall_i      = 1'b0;
      void'($urandom(78));
      gen_program();
      run_model();
      run_program(1'b0);                              // Reference run
      run_program(1'b1);                              // Same program, random stall
      $display("checks finished: %0d errors, %0d stores and %0d fetches per run",
               errors, exp_addr.size(), exp_fetch.size());
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
rv_pkg.sv
rv_ctrl_if.sv
fetch_unit.sv
decode_unit.sv
control_unit.sv
execute_unit.sv
store_unit.sv
rv_core_top.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation finished without failure"
